// ==== source/lsq_cfg_pkg.sv ====
`default_nettype none

package lsq_cfg_pkg;

   // ==============================
   // Data path widths
   // ==============================

   // Address and data word
   parameter int DATA_WIDTH     = 32;

   // Operand tag from the rename stage
   parameter int TAG_WIDTH      = 3;

   // Load destination register
   parameter int PHYS_REG_WIDTH = 6;

   // ==============================
   // Result bus
   // ==============================

   // Lanes snooped every cycle
   parameter int NUM_CDB = 3;

   // Tag value meaning the operand is already present
   parameter logic [TAG_WIDTH-1:0] TAG_READY = '0;

endpackage

`default_nettype wire

// ==== source/lsq_op_pkg.sv ====
`default_nettype none

package lsq_op_pkg;

   // Operation kind
   typedef enum logic {
      LSQ_LOAD  = 1'b0,
      LSQ_STORE = 1'b1
   } lsq_op_t;

   // Access size, 2'b11 is unused
   typedef enum logic [1:0] {
      SIZE_BYTE = 2'b00,
      SIZE_HALF = 2'b01,
      SIZE_WORD = 2'b10
   } mem_size_t;

   // Head entry progress
   typedef enum logic [1:0] {
      HEAD_IDLE         = 2'b00,
      HEAD_WAIT_RESP    = 2'b01,
      HEAD_RETIRE_LOAD  = 2'b10,
      HEAD_RETIRE_STORE = 2'b11
   } head_state_t;

   // Byte lanes touched by an access of this size at this offset
   function automatic logic [3:0] byte_enable(input mem_size_t size,
                                              input logic [1:0] addr_lo);
      logic [3:0] be;
      case (size)
         SIZE_WORD: be = 4'b1111;
         SIZE_HALF: be = 4'b0011 << {addr_lo[1], 1'b0};
         SIZE_BYTE: be = 4'b0001 << addr_lo;
         default:   be = 4'b0000;
      endcase
      return be;
   endfunction

endpackage

`default_nettype wire

// ==== source/lsq_ptr_ctrl.sv ====
`default_nettype none

module lsq_ptr_ctrl #(
   parameter int LSQ_DEPTH = 8
) (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         alloc_valid_i,
   input  logic                         retire_i,
   output logic                         alloc_en_o,
   output logic [$clog2(LSQ_DEPTH)-1:0] tail_idx_o,
   output logic [$clog2(LSQ_DEPTH)-1:0] head_idx_o,
   output logic                         alloc_ready_o,
   output logic                         lsq_full_o,
   output logic                         lsq_empty_o
);

   localparam int IDX_W = $clog2(LSQ_DEPTH);

   // Extra MSB tells a full queue from an empty one
   logic [IDX_W:0] head_ptr_q;
   logic [IDX_W:0] tail_ptr_q;
   logic [IDX_W:0] occupancy;

   // ==============================
   // Status
   // ==============================

   assign occupancy   = tail_ptr_q - head_ptr_q;
   assign lsq_empty_o = (head_ptr_q == tail_ptr_q);
   assign lsq_full_o  = (head_ptr_q[IDX_W] != tail_ptr_q[IDX_W]) &&
                        (head_ptr_q[IDX_W-1:0] == tail_ptr_q[IDX_W-1:0]);

   // Single lane, so one free slot is enough
   assign alloc_ready_o = !lsq_full_o;
   assign alloc_en_o    = alloc_valid_i && alloc_ready_o;

   assign tail_idx_o = tail_ptr_q[IDX_W-1:0];
   assign head_idx_o = head_ptr_q[IDX_W-1:0];

   // ==============================
   // Pointers
   // ==============================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         head_ptr_q <= '0;
         tail_ptr_q <= '0;
      end else begin
         if (alloc_en_o) begin
            tail_ptr_q <= tail_ptr_q + 1'b1;
         end
         if (retire_i) begin
            head_ptr_q <= head_ptr_q + 1'b1;
         end
      end
   end

   // Head issue must never retire from an empty queue
   a_no_retire_empty: assert property (@(posedge clk) disable iff (!rst_n)
      retire_i |-> !lsq_empty_o);

   a_occupancy_bound: assert property (@(posedge clk) disable iff (!rst_n)
      occupancy <= LSQ_DEPTH);

endmodule

`default_nettype wire

// ==== source/lsq_entry_array.sv ====
`default_nettype none

module lsq_entry_array #(
   parameter int LSQ_DEPTH = 8
) (
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  logic                                      alloc_en_i,
   input  logic [$clog2(LSQ_DEPTH)-1:0]              alloc_idx_i,
   input  lsq_op_pkg::lsq_op_t                       alloc_op_i,
   input  logic [lsq_cfg_pkg::PHYS_REG_WIDTH-1:0]    alloc_phys_reg_i,
   input  logic [lsq_cfg_pkg::TAG_WIDTH-1:0]         alloc_addr_tag_i,
   input  logic [lsq_cfg_pkg::TAG_WIDTH-1:0]         alloc_data_tag_i,
   input  logic [lsq_cfg_pkg::DATA_WIDTH-1:0]        alloc_data_i,
   input  lsq_op_pkg::mem_size_t                     alloc_size_i,
   input  logic                                      alloc_sign_ext_i,
   input  logic [lsq_cfg_pkg::NUM_CDB-1:0]           cdb_valid_i,
   input  logic [lsq_cfg_pkg::NUM_CDB-1:0][lsq_cfg_pkg::TAG_WIDTH-1:0]  cdb_tag_i,
   input  logic [lsq_cfg_pkg::NUM_CDB-1:0][lsq_cfg_pkg::DATA_WIDTH-1:0] cdb_data_i,
   input  logic [$clog2(LSQ_DEPTH)-1:0]              head_idx_i,
   input  logic                                      retire_i,
   output logic                                      head_valid_o,
   output lsq_op_pkg::lsq_op_t                       head_op_o,
   output logic                                      head_addr_valid_o,
   output logic [lsq_cfg_pkg::DATA_WIDTH-1:0]        head_addr_o,
   output logic                                      head_data_valid_o,
   output logic [lsq_cfg_pkg::DATA_WIDTH-1:0]        head_data_o,
   output lsq_op_pkg::mem_size_t                     head_size_o,
   output logic                                      head_sign_ext_o,
   output logic [lsq_cfg_pkg::PHYS_REG_WIDTH-1:0]    head_phys_reg_o
);

   import lsq_cfg_pkg::*;
   import lsq_op_pkg::*;

   localparam int IDX_W = $clog2(LSQ_DEPTH);

   // Control flags
   logic [LSQ_DEPTH-1:0] valid_q;
   logic [LSQ_DEPTH-1:0] addr_valid_q;
   logic [LSQ_DEPTH-1:0] data_valid_q;

   // Payload
   lsq_op_t                   op_q       [LSQ_DEPTH];
   logic [PHYS_REG_WIDTH-1:0] phys_reg_q [LSQ_DEPTH];
   mem_size_t                 size_q     [LSQ_DEPTH];
   logic [LSQ_DEPTH-1:0]      sign_ext_q;
   logic [TAG_WIDTH-1:0]      addr_tag_q [LSQ_DEPTH];
   logic [TAG_WIDTH-1:0]      data_tag_q [LSQ_DEPTH];
   logic [DATA_WIDTH-1:0]     addr_q     [LSQ_DEPTH];
   logic [DATA_WIDTH-1:0]     data_q     [LSQ_DEPTH];

   // Snoop results per entry
   logic                  alloc_data_rdy;
   logic [LSQ_DEPTH-1:0]  alloc_here;
   logic [LSQ_DEPTH-1:0]  addr_pend;
   logic [LSQ_DEPTH-1:0]  data_pend;
   logic [LSQ_DEPTH-1:0]  addr_hit;
   logic [LSQ_DEPTH-1:0]  data_hit;
   logic [TAG_WIDTH-1:0]  addr_tag_cur [LSQ_DEPTH];
   logic [TAG_WIDTH-1:0]  data_tag_cur [LSQ_DEPTH];
   logic [DATA_WIDTH-1:0] addr_cdb     [LSQ_DEPTH];
   logic [DATA_WIDTH-1:0] data_cdb     [LSQ_DEPTH];

   assign alloc_data_rdy = (alloc_op_i == LSQ_STORE) && (alloc_data_tag_i == TAG_READY);

   // ==============================
   // Result bus snoop
   // ==============================

   // The slot being written snoops with its incoming tags
   always_comb begin
      for (int i = 0; i < LSQ_DEPTH; i++) begin
         alloc_here[i] = alloc_en_i && (alloc_idx_i == IDX_W'(i));
         if (alloc_here[i]) begin
            addr_tag_cur[i] = alloc_addr_tag_i;
            data_tag_cur[i] = alloc_data_tag_i;
            addr_pend[i]    = 1'b1;
            data_pend[i]    = (alloc_op_i == LSQ_STORE) && !alloc_data_rdy;
         end else begin
            addr_tag_cur[i] = addr_tag_q[i];
            data_tag_cur[i] = data_tag_q[i];
            addr_pend[i]    = valid_q[i] && !addr_valid_q[i];
            data_pend[i]    = valid_q[i] && (op_q[i] == LSQ_STORE) && !data_valid_q[i];
         end

         addr_hit[i] = 1'b0;
         data_hit[i] = 1'b0;
         addr_cdb[i] = '0;
         data_cdb[i] = '0;
         // Walk down so the lowest matching lane wins
         for (int l = NUM_CDB - 1; l >= 0; l--) begin
            if (addr_pend[i] && cdb_valid_i[l] && (cdb_tag_i[l] == addr_tag_cur[i])) begin
               addr_hit[i] = 1'b1;
               addr_cdb[i] = cdb_data_i[l];
            end
            if (data_pend[i] && cdb_valid_i[l] && (cdb_tag_i[l] == data_tag_cur[i])) begin
               data_hit[i] = 1'b1;
               data_cdb[i] = cdb_data_i[l];
            end
         end
      end
   end

   // ==============================
   // Entry update
   // ==============================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q      <= '0;
         addr_valid_q <= '0;
         data_valid_q <= '0;
      end else begin
         for (int i = 0; i < LSQ_DEPTH; i++) begin
            if (alloc_here[i]) begin
               valid_q[i]      <= 1'b1;
               addr_valid_q[i] <= addr_hit[i];
               data_valid_q[i] <= alloc_data_rdy || data_hit[i];
            end else begin
               if (retire_i && (head_idx_i == IDX_W'(i))) begin
                  valid_q[i] <= 1'b0;
               end
               addr_valid_q[i] <= addr_valid_q[i] || addr_hit[i];
               data_valid_q[i] <= data_valid_q[i] || data_hit[i];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < LSQ_DEPTH; i++) begin
         if (alloc_here[i]) begin
            op_q[i]       <= alloc_op_i;
            phys_reg_q[i] <= alloc_phys_reg_i;
            size_q[i]     <= alloc_size_i;
            sign_ext_q[i] <= alloc_sign_ext_i;
            addr_tag_q[i] <= alloc_addr_tag_i;
            data_tag_q[i] <= alloc_data_tag_i;
            data_q[i]     <= alloc_data_i;
         end
         // A bus value overrides the allocation data
         if (addr_hit[i]) begin
            addr_q[i] <= addr_cdb[i];
         end
         if (data_hit[i]) begin
            data_q[i] <= data_cdb[i];
         end
      end
   end

   // Head read-out
   assign head_valid_o      = valid_q[head_idx_i];
   assign head_op_o         = op_q[head_idx_i];
   assign head_addr_valid_o = addr_valid_q[head_idx_i];
   assign head_addr_o       = addr_q[head_idx_i];
   assign head_data_valid_o = data_valid_q[head_idx_i];
   assign head_data_o       = data_q[head_idx_i];
   assign head_size_o       = size_q[head_idx_i];
   assign head_sign_ext_o   = sign_ext_q[head_idx_i];
   assign head_phys_reg_o   = phys_reg_q[head_idx_i];

   a_retire_valid: assert property (@(posedge clk) disable iff (!rst_n)
      retire_i |-> valid_q[head_idx_i]);

   // Pointer control must only grant a free slot
   a_alloc_free: assert property (@(posedge clk) disable iff (!rst_n)
      alloc_en_i |-> !valid_q[alloc_idx_i]);

endmodule

`default_nettype wire

// ==== source/lsq_head_issue.sv ====
`default_nettype none

module lsq_head_issue (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic                                   head_valid_i,
   input  lsq_op_pkg::lsq_op_t                    head_op_i,
   input  logic                                   head_addr_valid_i,
   input  logic [lsq_cfg_pkg::DATA_WIDTH-1:0]     head_addr_i,
   input  logic                                   head_data_valid_i,
   input  logic [lsq_cfg_pkg::DATA_WIDTH-1:0]     head_data_i,
   input  lsq_op_pkg::mem_size_t                  head_size_i,
   input  logic                                   head_sign_ext_i,
   input  logic [lsq_cfg_pkg::PHYS_REG_WIDTH-1:0] head_phys_reg_i,
   input  logic                                   mem_req_ready_i,
   input  logic                                   mem_resp_valid_i,
   input  logic [lsq_cfg_pkg::DATA_WIDTH-1:0]     mem_resp_data_i,
   output logic                                   mem_req_valid_o,
   output lsq_op_pkg::lsq_op_t                    mem_req_op_o,
   output logic [lsq_cfg_pkg::DATA_WIDTH-1:0]     mem_req_addr_o,
   output logic [lsq_cfg_pkg::DATA_WIDTH-1:0]     mem_req_data_o,
   output logic [3:0]                             mem_req_be_o,
   output lsq_op_pkg::mem_size_t                  mem_req_size_o,
   output logic                                   mem_req_sign_ext_o,
   output logic                                   retire_o,
   output logic                                   res_valid_o,
   output logic [lsq_cfg_pkg::PHYS_REG_WIDTH-1:0] res_phys_reg_o,
   output logic [lsq_cfg_pkg::DATA_WIDTH-1:0]     res_data_o
);

   import lsq_cfg_pkg::*;
   import lsq_op_pkg::*;

   head_state_t           state_q;
   head_state_t           state_d;
   logic                  operands_ok;
   logic [DATA_WIDTH-1:0] resp_data_q;

   // ==============================
   // Request
   // ==============================

   // Loads need only the address
   assign operands_ok = head_addr_valid_i && ((head_op_i == LSQ_LOAD) || head_data_valid_i);

   assign mem_req_valid_o    = (state_q == HEAD_IDLE) && head_valid_i && operands_ok;
   assign mem_req_op_o       = head_op_i;
   assign mem_req_addr_o     = head_addr_i;
   assign mem_req_data_o     = head_data_i;
   assign mem_req_size_o     = head_size_i;
   assign mem_req_sign_ext_o = head_sign_ext_i;
   assign mem_req_be_o       = byte_enable(head_size_i, head_addr_i[1:0]);

   // ==============================
   // Head FSM
   // ==============================

   always_comb begin
      state_d = state_q;
      case (state_q)
         HEAD_IDLE: begin
            if (mem_req_valid_o && mem_req_ready_i) begin
               state_d = HEAD_WAIT_RESP;
            end
         end
         HEAD_WAIT_RESP: begin
            if (mem_resp_valid_i) begin
               state_d = (head_op_i == LSQ_LOAD) ? HEAD_RETIRE_LOAD : HEAD_RETIRE_STORE;
            end
         end
         default: state_d = HEAD_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= HEAD_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Response word for the load result
   always_ff @(posedge clk) begin
      if ((state_q == HEAD_WAIT_RESP) && mem_resp_valid_i) begin
         resp_data_q <= mem_resp_data_i;
      end
   end

   // Both retire states last one cycle
   assign retire_o       = (state_q == HEAD_RETIRE_LOAD) || (state_q == HEAD_RETIRE_STORE);
   assign res_valid_o    = (state_q == HEAD_RETIRE_LOAD);
   assign res_phys_reg_o = head_phys_reg_i;
   assign res_data_o     = resp_data_q;

   // Request held steady by the entry array while memory stalls
   a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req_valid_o && !mem_req_ready_i |=>
         mem_req_valid_o && $stable(mem_req_op_o) && $stable(mem_req_addr_o) &&
         $stable(mem_req_data_o) && $stable(mem_req_be_o) &&
         $stable(mem_req_size_o) && $stable(mem_req_sign_ext_o));

   a_resp_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
      mem_resp_valid_i |-> state_q == HEAD_WAIT_RESP);

endmodule

`default_nettype wire

// ==== source/lsq_top.sv ====
`default_nettype none

module lsq_top #(
   parameter int LSQ_DEPTH = 8
) (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic                                   alloc_valid_i,
   input  lsq_op_pkg::lsq_op_t                    alloc_op_i,
   input  logic [lsq_cfg_pkg::PHYS_REG_WIDTH-1:0] alloc_phys_reg_i,
   input  logic [lsq_cfg_pkg::TAG_WIDTH-1:0]      alloc_addr_tag_i,
   input  logic [lsq_cfg_pkg::TAG_WIDTH-1:0]      alloc_data_tag_i,
   input  logic [lsq_cfg_pkg::DATA_WIDTH-1:0]     alloc_data_i,
   input  lsq_op_pkg::mem_size_t                  alloc_size_i,
   input  logic                                   alloc_sign_ext_i,
   output logic                                   alloc_ready_o,
   input  logic [lsq_cfg_pkg::NUM_CDB-1:0]        cdb_valid_i,
   input  logic [lsq_cfg_pkg::NUM_CDB-1:0][lsq_cfg_pkg::TAG_WIDTH-1:0]  cdb_tag_i,
   input  logic [lsq_cfg_pkg::NUM_CDB-1:0][lsq_cfg_pkg::DATA_WIDTH-1:0] cdb_data_i,
   output logic                                   mem_req_valid_o,
   output lsq_op_pkg::lsq_op_t                    mem_req_op_o,
   output logic [lsq_cfg_pkg::DATA_WIDTH-1:0]     mem_req_addr_o,
   output logic [lsq_cfg_pkg::DATA_WIDTH-1:0]     mem_req_data_o,
   output logic [3:0]                             mem_req_be_o,
   output lsq_op_pkg::mem_size_t                  mem_req_size_o,
   output logic                                   mem_req_sign_ext_o,
   input  logic                                   mem_req_ready_i,
   input  logic                                   mem_resp_valid_i,
   input  logic [lsq_cfg_pkg::DATA_WIDTH-1:0]     mem_resp_data_i,
   output logic                                   res_valid_o,
   output logic [lsq_cfg_pkg::PHYS_REG_WIDTH-1:0] res_phys_reg_o,
   output logic [lsq_cfg_pkg::DATA_WIDTH-1:0]     res_data_o,
   output logic                                   lsq_full_o,
   output logic                                   lsq_empty_o
);

   import lsq_cfg_pkg::*;
   import lsq_op_pkg::*;

   localparam int IDX_W = $clog2(LSQ_DEPTH);

   logic                      alloc_en;
   logic                      retire;
   logic [IDX_W-1:0]          tail_idx;
   logic [IDX_W-1:0]          head_idx;

   // Head entry fields
   logic                      head_valid;
   lsq_op_t                   head_op;
   logic                      head_addr_valid;
   logic [DATA_WIDTH-1:0]     head_addr;
   logic                      head_data_valid;
   logic [DATA_WIDTH-1:0]     head_data;
   mem_size_t                 head_size;
   logic                      head_sign_ext;
   logic [PHYS_REG_WIDTH-1:0] head_phys_reg;

   // ==============================
   // Pointers and status
   // ==============================

   lsq_ptr_ctrl #(
      .LSQ_DEPTH(LSQ_DEPTH)
   ) ptr_ctrl_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .alloc_valid_i(alloc_valid_i),
      .retire_i     (retire),
      .alloc_en_o   (alloc_en),
      .tail_idx_o   (tail_idx),
      .head_idx_o   (head_idx),
      .alloc_ready_o(alloc_ready_o),
      .lsq_full_o   (lsq_full_o),
      .lsq_empty_o  (lsq_empty_o)
   );

   // ==============================
   // Entry storage
   // ==============================

   lsq_entry_array #(
      .LSQ_DEPTH(LSQ_DEPTH)
   ) entry_array_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .alloc_en_i       (alloc_en),
      .alloc_idx_i      (tail_idx),
      .alloc_op_i       (alloc_op_i),
      .alloc_phys_reg_i (alloc_phys_reg_i),
      .alloc_addr_tag_i (alloc_addr_tag_i),
      .alloc_data_tag_i (alloc_data_tag_i),
      .alloc_data_i     (alloc_data_i),
      .alloc_size_i     (alloc_size_i),
      .alloc_sign_ext_i (alloc_sign_ext_i),
      .cdb_valid_i      (cdb_valid_i),
      .cdb_tag_i        (cdb_tag_i),
      .cdb_data_i       (cdb_data_i),
      .head_idx_i       (head_idx),
      .retire_i         (retire),
      .head_valid_o     (head_valid),
      .head_op_o        (head_op),
      .head_addr_valid_o(head_addr_valid),
      .head_addr_o      (head_addr),
      .head_data_valid_o(head_data_valid),
      .head_data_o      (head_data),
      .head_size_o      (head_size),
      .head_sign_ext_o  (head_sign_ext),
      .head_phys_reg_o  (head_phys_reg)
   );

   // ==============================
   // Head issue
   // ==============================

   lsq_head_issue head_issue_i (
      .clk               (clk),
      .rst_n             (rst_n),
      .head_valid_i      (head_valid),
      .head_op_i         (head_op),
      .head_addr_valid_i (head_addr_valid),
      .head_addr_i       (head_addr),
      .head_data_valid_i (head_data_valid),
      .head_data_i       (head_data),
      .head_size_i       (head_size),
      .head_sign_ext_i   (head_sign_ext),
      .head_phys_reg_i   (head_phys_reg),
      .mem_req_ready_i   (mem_req_ready_i),
      .mem_resp_valid_i  (mem_resp_valid_i),
      .mem_resp_data_i   (mem_resp_data_i),
      .mem_req_valid_o   (mem_req_valid_o),
      .mem_req_op_o      (mem_req_op_o),
      .mem_req_addr_o    (mem_req_addr_o),
      .mem_req_data_o    (mem_req_data_o),
      .mem_req_be_o      (mem_req_be_o),
      .mem_req_size_o    (mem_req_size_o),
      .mem_req_sign_ext_o(mem_req_sign_ext_o),
      .retire_o          (retire),
      .res_valid_o       (res_valid_o),
      .res_phys_reg_o    (res_phys_reg_o),
      .res_data_o        (res_data_o)
   );

endmodule

`default_nettype wire

// ==== bench/lsq_tb.sv ====
`default_nettype none

module lsq_tb;

   timeunit 1ns;
   timeprecision 1ns;

   import lsq_cfg_pkg::*;
   import lsq_op_pkg::*;

   localparam int LSQ_DEPTH = 8;
   localparam int TMO       = 400;

   logic clk;
   logic rst_n;
   logic alloc_valid_i;
   lsq_op_t alloc_op_i;
   logic [PHYS_REG_WIDTH-1:0] alloc_phys_reg_i;
   logic [TAG_WIDTH-1:0] alloc_addr_tag_i;
   logic [TAG_WIDTH-1:0] alloc_data_tag_i;
   logic [DATA_WIDTH-1:0] alloc_data_i;
   mem_size_t alloc_size_i;
   logic alloc_sign_ext_i;
   logic alloc_ready_o;
   logic [NUM_CDB-1:0] cdb_valid_i;
   logic [NUM_CDB-1:0][TAG_WIDTH-1:0] cdb_tag_i;
   logic [NUM_CDB-1:0][DATA_WIDTH-1:0] cdb_data_i;
   logic mem_req_valid_o;
   lsq_op_t mem_req_op_o;
   logic [DATA_WIDTH-1:0] mem_req_addr_o;
   logic [DATA_WIDTH-1:0] mem_req_data_o;
   logic [3:0] mem_req_be_o;
   mem_size_t mem_req_size_o;
   logic mem_req_sign_ext_o;
   logic mem_req_ready_i;
   logic mem_resp_valid_i;
   logic [DATA_WIDTH-1:0] mem_resp_data_i;
   logic res_valid_o;
   logic [PHYS_REG_WIDTH-1:0] res_phys_reg_o;
   logic [DATA_WIDTH-1:0] res_data_o;
   logic lsq_full_o;
   logic lsq_empty_o;

   int seed = 32'h15b61a05;
   int err_cnt = 0;
   int pass_cnt = 0;
   int fail_cnt = 0;

   // Reference queue in program order
   lsq_op_t               ref_op   [64];
   logic [DATA_WIDTH-1:0] ref_addr [64];
   logic [DATA_WIDTH-1:0] ref_data [64];
   mem_size_t             ref_size [64];
   logic                  ref_sx   [64];
   logic [PHYS_REG_WIDTH-1:0] ref_phys [64];
   int wr_cnt = 0;
   int req_cnt;

   // Values broadcast per tag
   logic [DATA_WIDTH-1:0] tag_val [8];

   // Memory model state
   logic outstanding;
   logic out_is_load;
   int   resp_wait;
   logic [DATA_WIDTH-1:0] resp_word;
   logic [DATA_WIDTH-1:0] exp_res_data;
   logic [PHYS_REG_WIDTH-1:0] exp_res_phys;
   logic full_expect;
   logic count_check;

   lsq_top #(
      .LSQ_DEPTH(LSQ_DEPTH)
   ) lsq_top_i (
      .clk(clk), .rst_n(rst_n),
      .alloc_valid_i(alloc_valid_i), .alloc_op_i(alloc_op_i),
      .alloc_phys_reg_i(alloc_phys_reg_i), .alloc_addr_tag_i(alloc_addr_tag_i),
      .alloc_data_tag_i(alloc_data_tag_i), .alloc_data_i(alloc_data_i),
      .alloc_size_i(alloc_size_i), .alloc_sign_ext_i(alloc_sign_ext_i),
      .alloc_ready_o(alloc_ready_o),
      .cdb_valid_i(cdb_valid_i), .cdb_tag_i(cdb_tag_i), .cdb_data_i(cdb_data_i),
      .mem_req_valid_o(mem_req_valid_o), .mem_req_op_o(mem_req_op_o),
      .mem_req_addr_o(mem_req_addr_o), .mem_req_data_o(mem_req_data_o),
      .mem_req_be_o(mem_req_be_o), .mem_req_size_o(mem_req_size_o),
      .mem_req_sign_ext_o(mem_req_sign_ext_o), .mem_req_ready_i(mem_req_ready_i),
      .mem_resp_valid_i(mem_resp_valid_i), .mem_resp_data_i(mem_resp_data_i),
      .res_valid_o(res_valid_o), .res_phys_reg_o(res_phys_reg_o),
      .res_data_o(res_data_o), .lsq_full_o(lsq_full_o), .lsq_empty_o(lsq_empty_o)
   );

   always #50 clk = ~clk;

   // Expected byte lanes from size and offset
   function automatic logic [3:0] expect_be(input mem_size_t sz, input logic [1:0] lo);
      logic [3:0] be;
      if (sz == SIZE_WORD) be = 4'hf;
      else if (sz == SIZE_HALF) be = lo[1] ? 4'hc : 4'h3;
      else be = 4'h1 << lo;
      return be;
   endfunction

   task automatic report_fail(input string msg);
      $display("FAIL %0t: %s", $time, msg);
      err_cnt++;
   endtask

   task automatic timeout_fail(input string what);
      $display("Timeout while waiting for %s", what);
      $display("Testbench failed");
      $finish;
   endtask

   // ==============================
   // Memory model
   // ==============================

   always @(posedge clk) begin
      if (!rst_n) begin
         outstanding <= 1'b0;
         req_cnt     <= 0;
         mem_req_ready_i  <= 1'b0;
         mem_resp_valid_i <= 1'b0;
      end else begin
         mem_req_ready_i  <= ($unsigned($random(seed)) % 4) != 0;
         mem_resp_valid_i <= 1'b0;
         if (outstanding) begin
            if (resp_wait == 0) begin
               resp_word = $random(seed);
               mem_resp_valid_i <= 1'b1;
               mem_resp_data_i  <= resp_word;
               exp_res_data     <= resp_word;
               outstanding      <= 1'b0;
            end else begin
               resp_wait <= resp_wait - 1;
            end
         end else if (mem_req_valid_o && mem_req_ready_i) begin
            outstanding  <= 1'b1;
            resp_wait    <= $unsigned($random(seed)) % 3;
            out_is_load  <= (mem_req_op_o == LSQ_LOAD);
            exp_res_phys <= ref_phys[req_cnt];
            req_cnt      <= req_cnt + 1;
         end
      end
   end

   // Response data bus idles at zero until the first response
   initial mem_resp_data_i = 32'h0;

   // ==============================
   // Checks
   // ==============================

   a_reset_state: assert property (@(posedge clk) $rose(rst_n) |->
      lsq_empty_o && alloc_ready_o && !lsq_full_o && !mem_req_valid_o && !res_valid_o)
      else report_fail("status after reset is wrong");

   a_req_fields: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req_valid_o && mem_req_ready_i |->
         mem_req_op_o == ref_op[req_cnt] && mem_req_addr_o == ref_addr[req_cnt] &&
         mem_req_size_o == ref_size[req_cnt] && mem_req_sign_ext_o == ref_sx[req_cnt] &&
         mem_req_be_o == expect_be(ref_size[req_cnt], ref_addr[req_cnt][1:0]) &&
         (ref_op[req_cnt] == LSQ_LOAD || mem_req_data_o == ref_data[req_cnt]))
      else report_fail("memory request differs from reference");

   a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o &&
         $stable(mem_req_op_o) && $stable(mem_req_addr_o) && $stable(mem_req_data_o) &&
         $stable(mem_req_be_o) && $stable(mem_req_size_o) && $stable(mem_req_sign_ext_o))
      else report_fail("request changed under back-pressure");

   a_load_result: assert property (@(posedge clk) disable iff (!rst_n)
      mem_resp_valid_i && out_is_load |=>
         res_valid_o && res_data_o == exp_res_data && res_phys_reg_o == exp_res_phys)
      else report_fail("load result wrong or missing");

   a_result_cause: assert property (@(posedge clk) disable iff (!rst_n)
      res_valid_o |-> $past(mem_resp_valid_i) && $past(out_is_load) && $past(res_valid_o) == 0)
      else report_fail("result pulse without a load response");

   a_full: assert property (@(posedge clk) disable iff (!rst_n)
      full_expect |-> lsq_full_o && !alloc_ready_o && !lsq_empty_o && !mem_req_valid_o)
      else report_fail("full queue status wrong");

   a_count: assert property (@(posedge clk) disable iff (!rst_n)
      count_check |-> req_cnt == wr_cnt)
      else report_fail("request count differs from allocation count");

   // ==============================
   // Stimulus tasks
   // ==============================

   task automatic alloc_entry(input lsq_op_t op, input int atag, input int dtag,
                              input logic [DATA_WIDTH-1:0] data, input int phys);
      int t;
      mem_size_t sz;
      logic sx;
      t  = 0;
      sz = mem_size_t'($unsigned($random(seed)) % 3);
      sx = $random(seed);
      @(posedge clk);
      while (!alloc_ready_o) begin
         t = t + 1;
         if (t > TMO) timeout_fail("alloc_ready_o");
         @(posedge clk);
      end
      alloc_valid_i    <= 1'b1;
      alloc_op_i       <= op;
      alloc_addr_tag_i <= atag;
      alloc_data_tag_i <= dtag;
      alloc_data_i     <= data;
      alloc_size_i     <= sz;
      alloc_sign_ext_i <= sx;
      alloc_phys_reg_i <= phys;
      ref_op[wr_cnt]   = op;
      ref_addr[wr_cnt] = tag_val[atag];
      ref_data[wr_cnt] = (dtag == TAG_READY) ? data : tag_val[dtag];
      ref_size[wr_cnt] = sz;
      ref_sx[wr_cnt]   = sx;
      ref_phys[wr_cnt] = phys;
      wr_cnt++;
      @(posedge clk);
      alloc_valid_i <= 1'b0;
   endtask

   task automatic broadcast(input int tag);
      int lane;
      lane = $unsigned($random(seed)) % NUM_CDB;
      @(posedge clk);
      cdb_valid_i[lane] <= 1'b1;
      cdb_tag_i[lane]   <= tag;
      cdb_data_i[lane]  <= tag_val[tag];
      @(posedge clk);
      cdb_valid_i <= '0;
   endtask

   task automatic drain_and_report(input string name, input int errs_before);
      int t;
      t = 0;
      @(posedge clk);
      while (!(lsq_empty_o && !outstanding && !mem_resp_valid_i && !res_valid_o)) begin
         t = t + 1;
         if (t > TMO) timeout_fail("the queue to drain");
         @(posedge clk);
      end
      count_check <= 1'b1;
      @(posedge clk);
      count_check <= 1'b0;
      @(posedge clk);
      if (err_cnt == errs_before) begin
         pass_cnt++;
         $display("Test %s: ok", name);
      end else begin
         fail_cnt++;
         $display("Test %s: errors", name);
      end
   endtask

   // ==============================
   // Test sequence
   // ==============================

   initial begin
      int e;
      clk = 1'b0;
      rst_n <= 1'b0;
      alloc_valid_i <= 1'b0;
      alloc_op_i <= LSQ_LOAD;
      alloc_phys_reg_i <= '0;
      alloc_addr_tag_i <= '0;
      alloc_data_tag_i <= '0;
      alloc_data_i <= '0;
      alloc_size_i <= SIZE_WORD;
      alloc_sign_ext_i <= 1'b0;
      cdb_valid_i <= '0;
      cdb_tag_i <= '0;
      cdb_data_i <= '0;
      mem_req_ready_i <= 1'b0;
      mem_resp_valid_i <= 1'b0;
      full_expect <= 1'b0;
      count_check <= 1'b0;
      out_is_load <= 1'b0;
      for (int i = 0; i < 8; i++) tag_val[i] = $random(seed);
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;

      e = err_cnt;
      drain_and_report("reset", e);

      // Fill with unresolved address tags, then one refused attempt
      e = err_cnt;
      for (int i = 0; i < LSQ_DEPTH; i++) alloc_entry(LSQ_LOAD, 1 + i % 7, 0, 0, i);
      full_expect <= 1'b1;
      alloc_valid_i    <= 1'b1;
      alloc_addr_tag_i <= 1;
      alloc_phys_reg_i <= 6'h3f;
      @(posedge clk);
      alloc_valid_i <= 1'b0;
      repeat (2) @(posedge clk);
      full_expect <= 1'b0;
      for (int t = 1; t < 8; t++) broadcast(t);
      drain_and_report("fill", e);

      e = err_cnt;
      alloc_entry(LSQ_LOAD, 1, 0, 0, 21);
      broadcast(1);
      drain_and_report("load", e);

      e = err_cnt;
      alloc_entry(LSQ_STORE, 2, TAG_READY, $random(seed), 0);
      alloc_entry(LSQ_STORE, 3, 4, $random(seed), 0);
      broadcast(3);
      broadcast(4);
      broadcast(2);
      drain_and_report("store", e);

      // Younger operands resolve first
      e = err_cnt;
      alloc_entry(LSQ_LOAD, 5, 0, 0, 11);
      alloc_entry(LSQ_LOAD, 6, 0, 0, 12);
      alloc_entry(LSQ_LOAD, 7, 0, 0, 13);
      alloc_entry(LSQ_LOAD, 1, 0, 0, 14);
      broadcast(1);
      broadcast(7);
      broadcast(6);
      broadcast(5);
      drain_and_report("order", e);

      $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && err_cnt == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
source/lsq_cfg_pkg.sv
source/lsq_op_pkg.sv
source/lsq_ptr_ctrl.sv
source/lsq_entry_array.sv
source/lsq_head_issue.sv
source/lsq_top.sv
bench/lsq_tb.sv
